// ==== design/reg_board_settings.svh ====
// Width settings for the register board: word, front-panel byte and microcode fields

`ifndef REG_BOARD_SETTINGS_SVH
`define REG_BOARD_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

`define REG_WIDTH    16   // Major register and processor bus width
`define FP_WIDTH     8    // Front panel data is one byte

//////////////////////////////////////////////////
// Microcode field widths
//////////////////////////////////////////////////

`define FIELD_WIDTH  5    // Bus read and write address fields
`define ACTION_WIDTH 4    // Action field, bit 3 is the enable

`endif

// ==== design/reg_board_pkg.sv ====
// Register board package: word, byte, field, register-select and strobe vector types

`include "reg_board_settings.svh"

package reg_board_pkg;

   //////////////////////////////////////////////////
   // Data types
   //////////////////////////////////////////////////

   typedef logic [`REG_WIDTH-1:0]    word_t;          // Register or bus word
   typedef logic [`FP_WIDTH-1:0]     fp_byte_t;       // Front panel byte

   //////////////////////////////////////////////////
   // Microcode fields
   //////////////////////////////////////////////////

   typedef logic [`FIELD_WIDTH-1:0]  addr_field_t;    // Read or write address
   typedef logic [`ACTION_WIDTH-1:0] action_field_t;  // Action code

   //////////////////////////////////////////////////
   // Register selection
   //////////////////////////////////////////////////

   // Numbering follows the low two bits of a bus address
   typedef enum logic [1:0] {
      sel_pc = 2'd0,                                  // Program counter
      sel_dr = 2'd1,                                  // Data register
      sel_ac = 2'd2,                                  // Accumulator
      sel_sp = 2'd3                                   // Stack pointer
   } reg_sel_e;

   // One strobe bit per major register, indexed by reg_sel_e
   typedef logic [3:0] strobe_vec_t;

endpackage

// ==== design/field_decoder.sv ====
// Microcode field decoder: read, write and action fields to per-register strobes

module field_decoder (
   input  reg_board_pkg::addr_field_t   raddr,       // Bus read address field
   input  reg_board_pkg::addr_field_t   waddr,       // Bus write address field
   input  reg_board_pkg::action_field_t action,      // Action field
   output reg_board_pkg::strobe_vec_t   read_sel,    // One-hot, register drives bus
   output logic                         read_valid,  // Some register drives bus
   output reg_board_pkg::strobe_vec_t   load,        // Register loads from bus
   output reg_board_pkg::strobe_vec_t   inc,         // Register counts up
   output reg_board_pkg::strobe_vec_t   dec          // Register counts down
);

   import reg_board_pkg::*;

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   // Board owns the address block with bit 4 low and bit 3 high.
   // Bit 2 high is the upper half of that block, which belongs to
   // another card, so it selects nothing here
   function automatic strobe_vec_t decode_addr(addr_field_t field);
      strobe_vec_t sel;
      sel = '0;
      if (!field[4] && field[3] && !field[2]) begin    // Our four addresses
         sel[reg_sel_e'(field[1:0])] = 1'b1;           // Low bits pick register
      end
      return sel;
   endfunction

   always_comb begin
      read_sel   = decode_addr(raddr);                // Bus read decoder
      read_valid = |read_sel;                         // Drive enable for bus
      load       = decode_addr(waddr);                // Write decoder, own field
   end

   //////////////////////////////////////////////////
   // Action decode
   //////////////////////////////////////////////////

   always_comb begin
      inc = '0;                                       // Idle unless enabled
      dec = '0;
      if (action[3]) begin                            // Action enable bit
         case (action[2:0])
            3'd0: inc[sel_pc] = 1'b1;                 // PC only counts up
            3'd2: inc[sel_dr] = 1'b1;
            3'd3: dec[sel_dr] = 1'b1;
            3'd4: inc[sel_ac] = 1'b1;
            3'd5: dec[sel_ac] = 1'b1;
            3'd6: inc[sel_sp] = 1'b1;
            3'd7: dec[sel_sp] = 1'b1;
            default: ;                                // Code 1 is a no-op
         endcase
      end
   end

   // Note that dec[sel_pc] stays low for every code, and no code
   // raises both inc and dec for one register

endmodule

// ==== design/reg_major.sv ====
// Major register: 16-bit storage with bus load, increment and decrement

module reg_major (
   input  logic                 clk4,     // Write strobe phase clock
   input  logic                 rst,      // Synchronous, active high
   input  reg_board_pkg::word_t ibus_in,  // Processor bus write data
   input  logic                 load,     // Load from bus
   input  logic                 inc,      // Count up by one
   input  logic                 dec,      // Count down by one
   output reg_board_pkg::word_t value     // Current register contents
);

   import reg_board_pkg::*;

   //////////////////////////////////////////////////
   // Counter step
   //////////////////////////////////////////////////

   word_t step;        // +1 or -1 as a word
   word_t count_next;  // Counted value
   word_t value_next;  // Value after this edge
   logic  count_en;    // Either action strobe

   // One shared adder serves both directions.
   // Minus one is all ones, so wraparound comes for free
   always_comb begin
      count_en   = inc | dec;
      step       = inc ? word_t'(1) : '1;            // Inc wins, never both
      count_next = value + step;                     // Modulo 2^16
   end

   //////////////////////////////////////////////////
   // Update priority
   //////////////////////////////////////////////////

   always_comb begin
      if (load) begin
         value_next = ibus_in;                       // Bus write beats action
      end else if (count_en) begin
         value_next = count_next;
      end else begin
         value_next = value;                         // Hold
      end
   end

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (rst) begin
         value <= '0;                                // All registers clear on reset
      end else begin
         value <= value_next;
      end
   end

endmodule

// ==== design/reg_readout.sv ====
// Register readout: bus read mux and drive enable, front panel byte, accumulator zero flag

`include "reg_board_settings.svh"

module reg_readout (
   input  reg_board_pkg::word_t       pc,          // Program counter
   input  reg_board_pkg::word_t       dr,          // Data register
   input  reg_board_pkg::word_t       ac,          // Accumulator
   input  reg_board_pkg::word_t       sp,          // Stack pointer
   input  reg_board_pkg::strobe_vec_t read_sel,    // One-hot bus read select
   input  logic                       read_valid,  // A register is selected
   input  logic                       fp_en,       // Front panel read enable
   input  reg_board_pkg::reg_sel_e    fp_reg,      // Front panel register
   input  logic                       fp_high,     // High byte when set
   output reg_board_pkg::word_t       ibus_out,    // Bus read data
   output logic                       ibus_drive,  // Bus drive enable
   output reg_board_pkg::fp_byte_t    fpd,         // Front panel data
   output logic                       fz           // Accumulator is zero
);

   import reg_board_pkg::*;

   word_t    regs [4];  // Registers in reg_sel_e order
   word_t    bus_word;  // Selected bus register
   word_t    fp_word;   // Selected panel register
   fp_byte_t fp_byte;   // Selected panel byte

   always_comb begin
      regs[sel_pc] = pc;
      regs[sel_dr] = dr;
      regs[sel_ac] = ac;
      regs[sel_sp] = sp;
   end

   //////////////////////////////////////////////////
   // Processor bus read
   //////////////////////////////////////////////////

   // Stands in for the four tristate buffers on the bus
   always_comb begin
      bus_word = '0;
      for (int i = 0; i < 4; i++) begin
         if (read_sel[i]) bus_word = regs[i];       // At most one bit set
      end
      ibus_out   = read_valid ? bus_word : '0;     // Quiet bus when idle
      ibus_drive = read_valid;
   end

   //////////////////////////////////////////////////
   // Front panel and flags
   //////////////////////////////////////////////////

   always_comb begin
      fp_word = regs[fp_reg];
      fp_byte = fp_high ? fp_word[`REG_WIDTH-1 -: `FP_WIDTH]  // Upper byte
                        : fp_word[`FP_WIDTH-1:0];             // Lower byte
      fpd     = fp_en ? fp_byte : '0;
      fz      = (ac == '0);                                   // Zero flag for ALU card
   end

endmodule

// ==== design/reg_board.sv ====
// Register board top level: field decoder, four major registers and readout stage

module reg_board (
   input  logic                         clk4,        // Write strobe phase clock
   input  logic                         rst,         // Synchronous, active high
   input  reg_board_pkg::addr_field_t   raddr,       // Microcode read address
   input  reg_board_pkg::addr_field_t   waddr,       // Microcode write address
   input  reg_board_pkg::action_field_t action,      // Microcode action
   input  reg_board_pkg::word_t         ibus_in,     // Bus data into the board
   output reg_board_pkg::word_t         ibus_out,    // Bus data out of the board
   output logic                         ibus_drive,  // Board drives the bus
   input  logic                         fp_en,       // Front panel read enable
   input  reg_board_pkg::reg_sel_e      fp_reg,      // Front panel register
   input  logic                         fp_high,     // Front panel high byte
   output reg_board_pkg::fp_byte_t      fpd,         // Front panel data
   output reg_board_pkg::word_t         pc_out,      // PC to neighbouring card
   output reg_board_pkg::word_t         ac_out,      // AC to neighbouring card
   output logic                         fz           // AC zero flag
);

   import reg_board_pkg::*;

   strobe_vec_t read_sel;    // Bus read select
   logic        read_valid;  // Bus read active
   strobe_vec_t load;        // Per-register loads
   strobe_vec_t inc;         // Per-register increments
   strobe_vec_t dec;         // Per-register decrements
   word_t       dr;          // Data register value
   word_t       sp;          // Stack pointer value

   //////////////////////////////////////////////////
   // Decoders
   //////////////////////////////////////////////////

   field_decoder decoder (
      .raddr(raddr), .waddr(waddr), .action(action),
      .read_sel(read_sel), .read_valid(read_valid),
      .load(load), .inc(inc), .dec(dec)
   );

   //////////////////////////////////////////////////
   // Major registers
   //////////////////////////////////////////////////

   reg_major reg_pc (                                // PC, dec strobe never set
      .clk4(clk4), .rst(rst), .ibus_in(ibus_in),
      .load(load[sel_pc]), .inc(inc[sel_pc]), .dec(dec[sel_pc]),
      .value(pc_out)
   );

   reg_major reg_dr (
      .clk4(clk4), .rst(rst), .ibus_in(ibus_in),
      .load(load[sel_dr]), .inc(inc[sel_dr]), .dec(dec[sel_dr]),
      .value(dr)
   );

   reg_major reg_ac (                                // Also exported
      .clk4(clk4), .rst(rst), .ibus_in(ibus_in),
      .load(load[sel_ac]), .inc(inc[sel_ac]), .dec(dec[sel_ac]),
      .value(ac_out)
   );

   reg_major reg_sp (
      .clk4(clk4), .rst(rst), .ibus_in(ibus_in),
      .load(load[sel_sp]), .inc(inc[sel_sp]), .dec(dec[sel_sp]),
      .value(sp)
   );

   //////////////////////////////////////////////////
   // Output stage
   //////////////////////////////////////////////////

   reg_readout readout (
      .pc(pc_out), .dr(dr), .ac(ac_out), .sp(sp),
      .read_sel(read_sel), .read_valid(read_valid),
      .fp_en(fp_en), .fp_reg(fp_reg), .fp_high(fp_high),
      .ibus_out(ibus_out), .ibus_drive(ibus_drive),
      .fpd(fpd), .fz(fz)
   );

endmodule

// ==== verification/reg_board_tb.sv ====
// Register board testbench: clock, reset, directed and random stimulus, reference model, checks

`include "reg_board_settings.svh"

module reg_board_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import reg_board_pkg::*;

   //////////////////////////////////////////////////
   // Run length and constants
   //////////////////////////////////////////////////

   localparam int RESET_CYCLES    = 10;
   localparam int DIRECTED_CYCLES = 200;                 // Upper bound, directed part
   localparam int RANDOM_CYCLES   = 2000;
   localparam int SLACK_CYCLES    = 790;                 // Roughly a third on top
   localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES
                                    + RANDOM_CYCLES + SLACK_CYCLES;
   localparam logic [31:0] SEED   = 32'h8ed9_7f10;

   localparam addr_field_t   IDLE_FIELD = 5'b00000;      // Selects no register
   localparam action_field_t NO_ACTION  = 4'b0000;       // Enable bit low
   localparam action_field_t NOOP_CODE  = 4'b1001;       // Enabled, code 1

   typedef logic [3:0][`REG_WIDTH-1:0] state_t;          // Modelled pc, dr, ac, sp

   logic          clk4;
   logic          rst;
   addr_field_t   raddr;
   addr_field_t   waddr;
   action_field_t action;
   word_t         ibus_in;
   word_t         ibus_out;
   logic          ibus_drive;
   logic          fp_en;
   reg_sel_e      fp_reg;
   logic          fp_high;
   fp_byte_t      fpd;
   word_t         pc_out;
   word_t         ac_out;
   logic          fz;

   state_t model;                                        // Reference register state
   string  test_name;                                    // Shown in error lines
   int     value_errors = 0;                             // Wrong output values
   int     other_errors = 0;                             // Timeout and the like
   int     cycle_count  = 0;

   reg_board reg_board_inst (
      .clk4(clk4), .rst(rst), .raddr(raddr), .waddr(waddr), .action(action),
      .ibus_in(ibus_in), .ibus_out(ibus_out), .ibus_drive(ibus_drive),
      .fp_en(fp_en), .fp_reg(fp_reg), .fp_high(fp_high), .fpd(fpd),
      .pc_out(pc_out), .ac_out(ac_out), .fz(fz)
   );

   initial begin
      clk4 = 1'b0;
      forever #5 clk4 = ~clk4;                           // 10 ns period
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Register index named by a bus field, -1 when the field is not ours
   function automatic int field_target(addr_field_t f);
      if (f[4] == 1'b0 && f[3] == 1'b1 && f[2] == 1'b0) return int'(f[1:0]);
      return -1;
   endfunction

   function automatic state_t next_state(state_t cur, addr_field_t wa,
                                         action_field_t act, word_t data);
      state_t nxt;
      int     target;
      nxt = cur;
      if (act[3]) begin                                  // Action table
         case (act[2:0])
            3'd0: nxt[sel_pc] = cur[sel_pc] + 16'd1;
            3'd2: nxt[sel_dr] = cur[sel_dr] + 16'd1;
            3'd3: nxt[sel_dr] = cur[sel_dr] - 16'd1;
            3'd4: nxt[sel_ac] = cur[sel_ac] + 16'd1;
            3'd5: nxt[sel_ac] = cur[sel_ac] - 16'd1;
            3'd6: nxt[sel_sp] = cur[sel_sp] + 16'd1;
            3'd7: nxt[sel_sp] = cur[sel_sp] - 16'd1;
            default: ;                                   // Code 1 does nothing
         endcase
      end
      target = field_target(wa);
      if (target >= 0) nxt[target] = data;               // Load overrides action
      return nxt;
   endfunction

   function automatic word_t bus_word_of(state_t s, addr_field_t ra);
      int target;
      target = field_target(ra);
      if (target < 0) return '0;                         // Undriven bus reads zero
      return s[target];
   endfunction

   function automatic logic bus_drive_of(addr_field_t ra);
      return field_target(ra) >= 0;
   endfunction

   function automatic fp_byte_t panel_byte_of(state_t s, logic en, reg_sel_e r, logic high);
      if (!en) return '0;
      if (high) return s[r][`REG_WIDTH-1 -: `FP_WIDTH];
      return s[r][`FP_WIDTH-1:0];
   endfunction

   function automatic logic zero_flag_of(state_t s);
      return s[sel_ac] == '0;
   endfunction

   // Model steps on the same edge as the DUT, inputs seen before their update
   always @(posedge clk4) begin
      if (rst) model <= '0;
      else     model <= next_state(model, waddr, action, ibus_in);
   end

   //////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////

   task automatic check_value(input string test, input string signal,
                              input logic [15:0] expected, input logic [15:0] actual);
      assert (actual === expected)
      else begin
         $display("error: test %s, %s expected %h actual %h", test, signal, expected, actual);
         value_errors++;
      end
   endtask

   // Outputs are settled at the falling edge
   always @(negedge clk4) begin
      if (!rst) begin
         check_value(test_name, "ibus_out", bus_word_of(model, raddr), ibus_out);
         check_value(test_name, "ibus_drive", 16'(bus_drive_of(raddr)), 16'(ibus_drive));
         check_value(test_name, "fpd", 16'(panel_byte_of(model, fp_en, fp_reg, fp_high)),
                     16'(fpd));
         check_value(test_name, "fz", 16'(zero_flag_of(model)), 16'(fz));
         check_value(test_name, "pc_out", model[sel_pc], pc_out);
         check_value(test_name, "ac_out", model[sel_ac], ac_out);
      end
   end

   task automatic report_counts();
      $display("Closing count: %0d wrong values, %0d other failures",
               value_errors, other_errors);
   endtask

   always @(posedge clk4) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         other_errors++;
         $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         report_counts();
         $display("Something failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   function automatic addr_field_t reg_addr(reg_sel_e r);
      return {2'b01, 1'b0, r};                           // Bit 4 low, bit 3 high
   endfunction

   function automatic action_field_t action_for(reg_sel_e r, logic down);
      return {1'b1, r, down};                            // Even codes up, odd codes down
   endfunction

   function automatic reg_sel_e random_reg();
      logic [1:0] v;
      v = 2'($urandom);
      return reg_sel_e'(v);
   endfunction

   task automatic drive_cycle(input string name, input addr_field_t ra, input addr_field_t wa,
                              input action_field_t act, input word_t data);
      @(posedge clk4);
      test_name = name;
      raddr   <= ra;
      waddr   <= wa;
      action  <= act;
      ibus_in <= data;
   endtask

   // Same time step as drive_cycle, no wait
   task automatic set_panel(input logic en, input reg_sel_e r, input logic high);
      fp_en   <= en;
      fp_reg  <= r;
      fp_high <= high;
   endtask

   task automatic bus_should_read(input string name, input word_t expected);
      @(negedge clk4);
      check_value(name, "ibus_out", expected, ibus_out);
   endtask

   task automatic panel_should_read(input string name, input fp_byte_t expected);
      @(negedge clk4);
      check_value(name, "fpd", 16'(expected), 16'(fpd));
   endtask

   task automatic flag_should_read(input string name, input logic expected);
      @(negedge clk4);
      check_value(name, "fz", 16'(expected), 16'(fz));
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      reg_sel_e r;
      word_t    words [4];
      words = '{16'h1234, 16'hBEEF, 16'h0F0F, 16'h8001};
      void'($urandom(SEED));
      rst       = 1'b1;
      raddr     = IDLE_FIELD;
      waddr     = IDLE_FIELD;
      action    = NO_ACTION;
      ibus_in   = '0;
      fp_en     = 1'b0;
      fp_reg    = sel_pc;
      fp_high   = 1'b0;
      test_name = "reset";
      repeat (RESET_CYCLES) @(posedge clk4);
      rst <= 1'b0;

      // All registers clear, bus quiet, zero flag set
      for (int i = 0; i < 4; i++) begin
         r = reg_sel_e'(i[1:0]);
         drive_cycle("reset", reg_addr(r), IDLE_FIELD, NO_ACTION, '0);
         bus_should_read("reset", 16'h0000);
      end
      drive_cycle("reset", IDLE_FIELD, IDLE_FIELD, NO_ACTION, '0);
      @(negedge clk4);
      check_value("reset", "ibus_drive", 16'h0000, 16'(ibus_drive));
      check_value("reset", "fz", 16'h0001, 16'(fz));

      // Write then read back, and a same-cycle read sees the old word
      for (int i = 0; i < 4; i++) begin
         drive_cycle("write", IDLE_FIELD, reg_addr(reg_sel_e'(i[1:0])), NO_ACTION, words[i]);
      end
      for (int i = 0; i < 4; i++) begin
         drive_cycle("readback", reg_addr(reg_sel_e'(i[1:0])), IDLE_FIELD, NO_ACTION, '0);
         bus_should_read("readback", words[i]);
      end
      drive_cycle("read_old", reg_addr(sel_dr), reg_addr(sel_dr), NO_ACTION, 16'h5555);
      bus_should_read("read_old", words[1]);
      drive_cycle("read_old", reg_addr(sel_dr), IDLE_FIELD, NO_ACTION, '0);
      bus_should_read("read_old", 16'h5555);

      // Wraparound both ways; the pc down code is the no-op
      for (int i = 0; i < 4; i++) begin
         r = reg_sel_e'(i[1:0]);
         drive_cycle("wrap", IDLE_FIELD, reg_addr(r), NO_ACTION, 16'hFFFF);
         drive_cycle("wrap", IDLE_FIELD, IDLE_FIELD, action_for(r, 1'b0), '0);
         drive_cycle("wrap", reg_addr(r), IDLE_FIELD, action_for(r, 1'b1), '0);
         bus_should_read("wrap", 16'h0000);
         drive_cycle("wrap", reg_addr(r), IDLE_FIELD, NO_ACTION, '0);
         bus_should_read("wrap", (r == sel_pc) ? 16'h0000 : 16'hFFFF);
      end

      // Disabled actions, the no-op code and foreign addresses change nothing
      for (int c = 0; c < 8; c++) begin
         drive_cycle("no_action", IDLE_FIELD, IDLE_FIELD, action_field_t'(c), 16'h0BAD);
      end
      drive_cycle("no_action", IDLE_FIELD, IDLE_FIELD, NOOP_CODE, 16'h0BAD);
      for (int v = 0; v < 32; v++) begin
         if (field_target(addr_field_t'(v)) < 0) begin
            drive_cycle("bad_field", addr_field_t'(v), addr_field_t'(v), NO_ACTION, 16'hDEAD);
         end
      end
      for (int i = 0; i < 4; i++) begin
         drive_cycle("unchanged", reg_addr(reg_sel_e'(i[1:0])), IDLE_FIELD, NO_ACTION, '0);
         bus_should_read("unchanged", (i == 0) ? 16'h0000 : 16'hFFFF);
      end

      // Load and action on one register in one cycle
      for (int i = 0; i < 4; i++) begin
         r = reg_sel_e'(i[1:0]);
         drive_cycle("load_wins", IDLE_FIELD, reg_addr(r), action_for(r, i[0]), words[i]);
         drive_cycle("load_wins", reg_addr(r), IDLE_FIELD, NO_ACTION, '0);
         bus_should_read("load_wins", words[i]);
      end

      // Front panel bytes, then disabled panel
      for (int i = 0; i < 4; i++) begin
         r = reg_sel_e'(i[1:0]);
         for (int h = 0; h < 2; h++) begin
            drive_cycle("panel", IDLE_FIELD, IDLE_FIELD, NO_ACTION, '0);
            set_panel(1'b1, r, h[0]);
            panel_should_read("panel", (h == 1) ? words[i][15:8] : words[i][7:0]);
         end
         drive_cycle("panel_off", IDLE_FIELD, IDLE_FIELD, NO_ACTION, '0);
         set_panel(1'b0, r, 1'b1);
         panel_should_read("panel_off", 8'h00);
      end

      // Zero flag follows the accumulator
      drive_cycle("zero_flag", IDLE_FIELD, reg_addr(sel_ac), NO_ACTION, 16'h0000);
      drive_cycle("zero_flag", IDLE_FIELD, IDLE_FIELD, action_for(sel_ac, 1'b1), '0);
      flag_should_read("zero_flag", 1'b1);
      drive_cycle("zero_flag", IDLE_FIELD, IDLE_FIELD, action_for(sel_ac, 1'b0), '0);
      flag_should_read("zero_flag", 1'b0);                // Now 16'hFFFF
      drive_cycle("zero_flag", IDLE_FIELD, IDLE_FIELD, NO_ACTION, '0);
      flag_should_read("zero_flag", 1'b1);

      // Random run, writes biased toward valid addresses
      for (int n = 0; n < RANDOM_CYCLES; n++) begin
         @(posedge clk4);
         test_name = "random";
         raddr   <= addr_field_t'($urandom);
         waddr   <= ($urandom % 2 == 0) ? reg_addr(random_reg()) : addr_field_t'($urandom);
         action  <= action_field_t'($urandom);
         ibus_in <= ($urandom % 8 == 0) ? word_t'(0) : word_t'($urandom);
         fp_en   <= 1'($urandom);
         fp_reg  <= random_reg();
         fp_high <= 1'($urandom);
      end

      drive_cycle("final", IDLE_FIELD, IDLE_FIELD, NO_ACTION, '0);
      repeat (2) @(posedge clk4);                          // Last falling-edge checks done
      report_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+design
design/reg_board_pkg.sv
design/field_decoder.sv
design/reg_major.sv
design/reg_readout.sv
design/reg_board.sv
verification/reg_board_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the register board testbench with Verilator and run it.
# The run passes only if the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module reg_board_tb \
   -Mdir obj_dir -o reg_board_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed, see build.log"; exit 1; }

./obj_dir/reg_board_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -qx "Everything OK" sim.log && echo "PASS" && exit 0 \
   || { echo "FAIL"; exit 1; }
